/* source/csr_cfg.svh */
//////////////////////////////
// Sizes, info register values and reset values
// for the machine-mode CSR file; include where needed
//////////////////////////////
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN              32
`define CSR_CNT_W             64
`define CSR_HARTID            32'd0

`define CSR_MVENDORID         32'h0000_0000
`define CSR_MARCHID           32'h0000_0001
`define CSR_MIMPID            32'h0000_0112
`define CSR_MCONFIGPTR        32'h0000_0000
`define CSR_MISA_VAL          32'h4000_1100  // MXL=1, I and M

`define CSR_MSTATUS_RST       32'h0020_0000  // tw only
`define CSR_MTVEC_RST         32'h0000_0000
`define CSR_MCOUNTEREN_RST    32'hffff_ffff
`define CSR_MCOUNTINHIBIT_RST 32'h0000_0000
`define CSR_IRQ_MASK          32'h0000_0888  // meie, mtie, msie

`endif

/* source/csr_addr_pkg.sv */
//////////////////////////////
// CSR address map and access opcodes
//////////////////////////////
package csr_addr_pkg;

  // [11:10] == 2'b11 is read-only space, [9:8] is minimum privilege
  typedef enum logic [11:0] {
    MSTATUS_ADDR       = 12'h300,
    MISA_ADDR          = 12'h301,
    MIE_ADDR           = 12'h304,
    MTVEC_ADDR         = 12'h305,
    MCOUNTEREN_ADDR    = 12'h306,
    MSTATUSH_ADDR      = 12'h310,
    MCOUNTINHIBIT_ADDR = 12'h320,
    MSCRATCH_ADDR      = 12'h340,
    MEPC_ADDR          = 12'h341,
    MCAUSE_ADDR        = 12'h342,
    MTVAL_ADDR         = 12'h343,
    MIP_ADDR           = 12'h344,
    MCYCLE_ADDR        = 12'hb00,
    MINSTRET_ADDR      = 12'hb02,
    MCYCLEH_ADDR       = 12'hb80,
    MINSTRETH_ADDR     = 12'hb82,
    CYCLE_ADDR         = 12'hc00,  // User views
    TIME_ADDR          = 12'hc01,
    INSTRET_ADDR       = 12'hc02,
    CYCLEH_ADDR        = 12'hc80,
    TIMEH_ADDR         = 12'hc81,
    INSTRETH_ADDR      = 12'hc82,
    MVENDORID_ADDR     = 12'hf11,
    MARCHID_ADDR       = 12'hf12,
    MIMPID_ADDR        = 12'hf13,
    MHARTID_ADDR       = 12'hf14,
    MCONFIGPTR_ADDR    = 12'hf15
  } csr_addr_t;

  typedef enum logic [1:0] {NONE, WRITE, SET, CLEAR} csr_op_t;

endpackage

/* source/csr_types_pkg.sv */
//////////////////////////////
// Register layouts and port bundles of the CSR file
//////////////////////////////
`include "csr_cfg.svh"

package csr_types_pkg;

  typedef logic [`CSR_XLEN-1:0] csr_word_t;

  typedef enum logic [1:0] {U_MODE, S_MODE, RESERVED_MODE, M_MODE} priv_level_t;

  typedef enum logic [1:0] {DIRECT, VECTORED} mtvec_mode_t;

  typedef struct packed {
    logic        sd;
    logic [7:0]  wpri_30_23;
    logic        tsr;
    logic        tw;
    logic        tvm;
    logic        mxr;
    logic        sum;
    logic        mprv;
    logic [1:0]  xs;
    logic [1:0]  fs;
    priv_level_t mpp;
    logic [1:0]  vs;
    logic        spp;
    logic        mpie;
    logic        ube;
    logic        spie;
    logic        wpri_4;
    logic        mie;
    logic        wpri_2;
    logic        sie;
    logic        wpri_0;
  } mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    mtvec_mode_t mode;
  } mtvec_t;

  typedef struct packed {
    logic [19:0] zero_31_12;
    logic        meie;
    logic [2:0]  zero_10_8;
    logic        mtie;
    logic [2:0]  zero_6_4;
    logic        msie;
    logic [2:0]  zero_2_0;
  } mie_t;

  typedef struct packed {
    logic [19:0] zero_31_12;
    logic        meip;
    logic [2:0]  zero_10_8;
    logic        mtip;
    logic [2:0]  zero_6_4;
    logic        msip;
    logic [2:0]  zero_2_0;
  } mip_t;

  typedef struct packed {
    logic [28:0] hpm;
    logic        ir;
    logic        tm;
    logic        cy;
  } mcounter_t;

  typedef struct packed {
    logic                   valid;
    csr_addr_pkg::csr_op_t  op;
    csr_addr_pkg::csr_addr_t addr;
    csr_word_t              wdata;
    priv_level_t            priv;
  } csr_req_t;

  typedef struct packed {
    logic                    en;
    csr_addr_pkg::csr_addr_t addr;
    csr_word_t               data;  // Merged next value
  } csr_wr_t;

  typedef struct packed {
    logic      inject_mstatus;
    logic      inject_mepc;
    logic      inject_mcause;
    logic      inject_mtval;
    logic      inject_mie;
    logic      inject_mip;
    mstatus_t  mstatus;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mtval;
    mie_t      mie;
    mip_t      mip;
  } trap_update_t;

  typedef struct packed {
    mstatus_t  mstatus;
    mtvec_t    mtvec;
    mie_t      mie;
    mip_t      mip;
    csr_word_t mepc;
    csr_word_t mcause;
  } trap_state_t;

  typedef struct packed {
    logic [`CSR_CNT_W-1:0] cycle;
    logic [`CSR_CNT_W-1:0] instret;
  } counter_state_t;

endpackage

/* source/csr_access_check.sv */
//////////////////////////////
// Opcode merge and permission check of one CSR access
//////////////////////////////
`timescale 1ns/100ps

module csr_access_check (
  input  csr_types_pkg::csr_req_t  req,
  input  csr_types_pkg::csr_word_t old_val,
  output csr_types_pkg::csr_wr_t   wr,
  output logic                     priv_fault
);

  logic modify;
  logic ro_space;
  logic low_priv;
  logic [11:0] addr_bits;

  assign addr_bits = req.addr;
  assign modify    = (req.op != csr_addr_pkg::NONE);
  assign ro_space  = (addr_bits[11:10] == 2'b11);
  assign low_priv  = (addr_bits[9:8] > req.priv);  // Needs higher mode

  always_comb begin
    case (req.op)
      csr_addr_pkg::WRITE: wr.data = req.wdata;
      csr_addr_pkg::SET:   wr.data = old_val | req.wdata;
      csr_addr_pkg::CLEAR: wr.data = old_val & ~req.wdata;
      default:             wr.data = old_val;
    endcase
  end

  assign wr.addr = req.addr;

  // Only a modifying access can fault
  assign priv_fault = req.valid & modify & (ro_space | low_priv);
  assign wr.en      = req.valid & modify & ~ro_space & ~low_priv;

endmodule

/* source/machine_trap_csrs.sv */
//////////////////////////////
// Machine trap setup and trap handling registers
// Legalizes CSR writes; trap injection wins
//////////////////////////////
`timescale 1ns/100ps
`include "csr_cfg.svh"

module machine_trap_csrs (
  input  logic                         CLK,
  input  logic                         nRST,
  input  csr_types_pkg::csr_wr_t       wr,
  input  csr_types_pkg::trap_update_t  trap_upd,
  output csr_types_pkg::trap_state_t   trap_state,
  output csr_types_pkg::csr_word_t     mscratch,
  output csr_types_pkg::csr_word_t     mtval,
  output csr_types_pkg::mcounter_t     mcounteren,
  output csr_types_pkg::mcounter_t     mcountinhibit
);

  csr_types_pkg::mstatus_t  mstatus, mstatus_next;
  csr_types_pkg::mtvec_t    mtvec, mtvec_next;
  csr_types_pkg::mie_t      mie, mie_next;
  csr_types_pkg::mip_t      mip, mip_next;
  csr_types_pkg::csr_word_t mepc, mepc_next;
  csr_types_pkg::csr_word_t mcause, mcause_next;
  csr_types_pkg::csr_word_t mscratch_next, mtval_next;
  csr_types_pkg::mcounter_t mcounteren_next, mcountinhibit_next;

  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mip_next           = mip;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mscratch_next      = mscratch;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (wr.en) begin
      case (wr.addr)
        csr_addr_pkg::MSTATUS_ADDR: begin
          mstatus_next.mie  = wr.data[3];
          mstatus_next.mpie = wr.data[7];
          mstatus_next.mprv = wr.data[17];
          mstatus_next.tw   = wr.data[21];
          if (wr.data[12:11] == csr_types_pkg::S_MODE ||
              wr.data[12:11] == csr_types_pkg::RESERVED_MODE) begin
            mstatus_next.mpp = csr_types_pkg::U_MODE;  // No S-mode here
          end else begin
            mstatus_next.mpp = csr_types_pkg::priv_level_t'(wr.data[12:11]);
          end
        end
        csr_addr_pkg::MTVEC_ADDR: begin
          mtvec_next.base = wr.data[31:2];
          mtvec_next.mode = (wr.data[1:0] > 2'b01) ? csr_types_pkg::DIRECT :
                            csr_types_pkg::mtvec_mode_t'(wr.data[1:0]);
        end
        csr_addr_pkg::MIE_ADDR:           mie_next = wr.data & `CSR_IRQ_MASK;
        csr_addr_pkg::MIP_ADDR:           mip_next = wr.data & `CSR_IRQ_MASK;
        csr_addr_pkg::MSCRATCH_ADDR:      mscratch_next = wr.data;
        csr_addr_pkg::MEPC_ADDR:          mepc_next = wr.data;
        csr_addr_pkg::MCAUSE_ADDR:        mcause_next = wr.data;
        csr_addr_pkg::MTVAL_ADDR:         mtval_next = wr.data;
        csr_addr_pkg::MCOUNTEREN_ADDR:    mcounteren_next = wr.data;
        csr_addr_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit_next = wr.data;
        default: ;
      endcase
    end

    // Privilege controller updates
    if (trap_upd.inject_mstatus) mstatus_next = trap_upd.mstatus;
    if (trap_upd.inject_mepc)    mepc_next    = trap_upd.mepc;
    if (trap_upd.inject_mcause)  mcause_next  = trap_upd.mcause;
    if (trap_upd.inject_mtval)   mtval_next   = trap_upd.mtval;
    if (trap_upd.inject_mie)     mie_next     = trap_upd.mie;
    if (trap_upd.inject_mip)     mip_next     = trap_upd.mip;

    // No F, V or custom state
    mstatus_next.sd = 1'b0;
    mstatus_next.xs = 2'b00;
    mstatus_next.fs = 2'b00;
    mstatus_next.vs = 2'b00;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= csr_types_pkg::mstatus_t'(`CSR_MSTATUS_RST);
      mtvec         <= csr_types_pkg::mtvec_t'(`CSR_MTVEC_RST);
      mie           <= '0;
      mip           <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mscratch      <= '0;
      mtval         <= '0;
      mcounteren    <= csr_types_pkg::mcounter_t'(`CSR_MCOUNTEREN_RST);
      mcountinhibit <= csr_types_pkg::mcounter_t'(`CSR_MCOUNTINHIBIT_RST);
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mscratch      <= mscratch_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

  assign trap_state.mstatus = mstatus;
  assign trap_state.mtvec   = mtvec;
  assign trap_state.mie     = mie;
  assign trap_state.mip     = mip;
  assign trap_state.mepc    = mepc;
  assign trap_state.mcause  = mcause;

endmodule

/* source/perf_counters.sv */
//////////////////////////////
// 64-bit mcycle and minstret with inhibit
// A half write replaces that cycle's increment
//////////////////////////////
`timescale 1ns/100ps
`include "csr_cfg.svh"

module perf_counters (
  input  logic                          CLK,
  input  logic                          nRST,
  input  csr_types_pkg::csr_wr_t        wr,
  input  logic                          inst_ret,
  input  csr_types_pkg::mcounter_t      mcountinhibit,
  output csr_types_pkg::counter_state_t counters
);

  csr_types_pkg::counter_state_t cnt_next;

  always_comb begin
    cnt_next = counters;
    if (!mcountinhibit.cy) cnt_next.cycle = counters.cycle + `CSR_CNT_W'(1);
    if (!mcountinhibit.ir) cnt_next.instret = counters.instret + `CSR_CNT_W'(inst_ret);

    if (wr.en) begin
      case (wr.addr)
        csr_addr_pkg::MCYCLE_ADDR:    cnt_next.cycle = {counters.cycle[`CSR_CNT_W-1:`CSR_XLEN],
                                                        wr.data};
        csr_addr_pkg::MCYCLEH_ADDR:   cnt_next.cycle = {wr.data, counters.cycle[`CSR_XLEN-1:0]};
        csr_addr_pkg::MINSTRET_ADDR:  cnt_next.instret = {counters.instret[`CSR_CNT_W-1:`CSR_XLEN],
                                                          wr.data};
        csr_addr_pkg::MINSTRETH_ADDR: cnt_next.instret = {wr.data,
                                                          counters.instret[`CSR_XLEN-1:0]};
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      counters <= '0;
    end else begin
      counters <= cnt_next;
    end
  end

endmodule

/* source/csr_read_mux.sv */
//////////////////////////////
// Old-value select by address, user counter gating
// and unknown address detection
//////////////////////////////
`timescale 1ns/100ps
`include "csr_cfg.svh"

module csr_read_mux (
  input  csr_types_pkg::csr_req_t       req,
  input  csr_types_pkg::trap_state_t    trap_state,
  input  csr_types_pkg::csr_word_t      mscratch,
  input  csr_types_pkg::csr_word_t      mtval,
  input  csr_types_pkg::mcounter_t      mcounteren,
  input  csr_types_pkg::mcounter_t      mcountinhibit,
  input  csr_types_pkg::counter_state_t counters,
  input  logic [`CSR_CNT_W-1:0]         mtime,
  output csr_types_pkg::csr_word_t      rdata,
  output logic                          addr_fault
);

  logic                     view_hit;  // User counter view address
  logic                     view_en;
  csr_types_pkg::csr_word_t view_val;
  logic                     u_mode;

  assign u_mode = (req.priv == csr_types_pkg::U_MODE);

  always_comb begin
    view_hit = 1'b1;
    view_en  = 1'b1;
    view_val = '0;
    case (req.addr)
      csr_addr_pkg::CYCLE_ADDR: begin
        view_en  = mcounteren.cy;
        view_val = counters.cycle[`CSR_XLEN-1:0];
      end
      csr_addr_pkg::CYCLEH_ADDR: begin
        view_en  = mcounteren.cy;
        view_val = counters.cycle[`CSR_CNT_W-1:`CSR_XLEN];
      end
      csr_addr_pkg::INSTRET_ADDR: begin
        view_en  = mcounteren.ir;
        view_val = counters.instret[`CSR_XLEN-1:0];
      end
      csr_addr_pkg::INSTRETH_ADDR: begin
        view_en  = mcounteren.ir;
        view_val = counters.instret[`CSR_CNT_W-1:`CSR_XLEN];
      end
      csr_addr_pkg::TIME_ADDR: begin
        view_en  = mcounteren.tm;
        view_val = mtime[`CSR_XLEN-1:0];
      end
      csr_addr_pkg::TIMEH_ADDR: begin
        view_en  = mcounteren.tm;
        view_val = mtime[`CSR_CNT_W-1:`CSR_XLEN];
      end
      default: view_hit = 1'b0;
    endcase
  end

  always_comb begin
    rdata      = '0;
    addr_fault = 1'b0;
    case (req.addr)
      csr_addr_pkg::MVENDORID_ADDR:     rdata = `CSR_MVENDORID;
      csr_addr_pkg::MARCHID_ADDR:       rdata = `CSR_MARCHID;
      csr_addr_pkg::MIMPID_ADDR:        rdata = `CSR_MIMPID;
      csr_addr_pkg::MHARTID_ADDR:       rdata = `CSR_HARTID;
      csr_addr_pkg::MCONFIGPTR_ADDR:    rdata = `CSR_MCONFIGPTR;
      csr_addr_pkg::MISA_ADDR:          rdata = `CSR_MISA_VAL;
      csr_addr_pkg::MSTATUSH_ADDR:      rdata = '0;  // Little endian only
      csr_addr_pkg::MSTATUS_ADDR:       rdata = trap_state.mstatus;
      csr_addr_pkg::MTVEC_ADDR:         rdata = trap_state.mtvec;
      csr_addr_pkg::MIE_ADDR:           rdata = trap_state.mie;
      csr_addr_pkg::MIP_ADDR:           rdata = trap_state.mip;
      csr_addr_pkg::MEPC_ADDR:          rdata = trap_state.mepc;
      csr_addr_pkg::MCAUSE_ADDR:        rdata = trap_state.mcause;
      csr_addr_pkg::MSCRATCH_ADDR:      rdata = mscratch;
      csr_addr_pkg::MTVAL_ADDR:         rdata = mtval;
      csr_addr_pkg::MCOUNTEREN_ADDR:    rdata = mcounteren;
      csr_addr_pkg::MCOUNTINHIBIT_ADDR: rdata = mcountinhibit;
      csr_addr_pkg::MCYCLE_ADDR:        rdata = counters.cycle[`CSR_XLEN-1:0];
      csr_addr_pkg::MCYCLEH_ADDR:       rdata = counters.cycle[`CSR_CNT_W-1:`CSR_XLEN];
      csr_addr_pkg::MINSTRET_ADDR:      rdata = counters.instret[`CSR_XLEN-1:0];
      csr_addr_pkg::MINSTRETH_ADDR:     rdata = counters.instret[`CSR_CNT_W-1:`CSR_XLEN];
      default: begin
        if (view_hit) begin
          if (u_mode && !view_en) begin
            addr_fault = req.valid;  // Blocked by mcounteren
          end else begin
            rdata = view_val;
          end
        end else begin
          // Nothing lives at this address
          addr_fault = req.valid && (req.op != csr_addr_pkg::NONE);
        end
      end
    endcase
  end

endmodule

/* source/csr_file.sv */
//////////////////////////////
// Machine-mode CSR file top
// Combinational read, write commits on next edge
//////////////////////////////
`timescale 1ns/100ps
`include "csr_cfg.svh"

module csr_file (
  input  logic                         CLK,
  input  logic                         nRST,
  input  csr_types_pkg::csr_req_t      req,
  input  csr_types_pkg::trap_update_t  trap_upd,
  input  logic [`CSR_CNT_W-1:0]        mtime,
  input  logic                         inst_ret,
  output csr_types_pkg::csr_word_t     rdata,
  output logic                         invalid,
  output csr_types_pkg::trap_state_t   trap_state
);

  csr_types_pkg::csr_wr_t        wr;
  csr_types_pkg::csr_word_t      mscratch;
  csr_types_pkg::csr_word_t      mtval;
  csr_types_pkg::mcounter_t      mcounteren;
  csr_types_pkg::mcounter_t      mcountinhibit;
  csr_types_pkg::counter_state_t counters;
  logic                          priv_fault;
  logic                          addr_fault;

  csr_access_check i_access_check (
    .req        (req),
    .old_val    (rdata),  // Merge uses the old value
    .wr         (wr),
    .priv_fault (priv_fault)
  );

  machine_trap_csrs i_trap_csrs (
    .CLK           (CLK),
    .nRST          (nRST),
    .wr            (wr),
    .trap_upd      (trap_upd),
    .trap_state    (trap_state),
    .mscratch      (mscratch),
    .mtval         (mtval),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit)
  );

  perf_counters i_perf_counters (
    .CLK           (CLK),
    .nRST          (nRST),
    .wr            (wr),
    .inst_ret      (inst_ret),
    .mcountinhibit (mcountinhibit),
    .counters      (counters)
  );

  csr_read_mux i_read_mux (
    .req           (req),
    .trap_state    (trap_state),
    .mscratch      (mscratch),
    .mtval         (mtval),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit),
    .counters      (counters),
    .mtime         (mtime),
    .rdata         (rdata),
    .addr_fault    (addr_fault)
  );

  assign invalid = priv_fault | addr_fault;

endmodule

/* sim/csr_file_asserts.sv */
//////////////////////////////
// Concurrent checks bound into the CSR file top
//////////////////////////////
`timescale 1ns/100ps

module csr_file_asserts (
  input logic                       CLK,
  input logic                       nRST,
  input csr_types_pkg::csr_req_t    req,
  input logic                       invalid,
  input csr_types_pkg::trap_state_t trap_state
);

  int unsigned fail_count = 0;

  // WARL fields only ever hold legal values
  a_mtvec_mode: assert property (@(posedge CLK) disable iff (!nRST)
    trap_state.mtvec.mode <= csr_types_pkg::VECTORED)
    else begin
      $error("mtvec mode above vectored");
      fail_count++;
    end

  a_mpp_legal: assert property (@(posedge CLK) disable iff (!nRST)
    trap_state.mstatus.mpp != csr_types_pkg::S_MODE &&
    trap_state.mstatus.mpp != csr_types_pkg::RESERVED_MODE)
    else begin
      $error("mstatus mpp holds S or reserved");
      fail_count++;
    end

  a_quiet_invalid: assert property (@(posedge CLK) disable iff (!nRST)
    !req.valid |-> !invalid)
    else begin
      $error("invalid raised without a request");
      fail_count++;
    end

endmodule

/* sim/csr_file_tb.sv */
//////////////////////////////
// Testbench of the CSR file
// Runs a table of accesses, one per cycle, and checks
// the read data and the invalid flag of every row
//////////////////////////////
`timescale 1ns/100ps
`include "csr_cfg.svh"

module csr_file_tb;

  typedef struct packed {
    csr_types_pkg::csr_req_t     req;
    csr_types_pkg::trap_update_t upd;
    logic [`CSR_CNT_W-1:0]       mtime;
    csr_types_pkg::csr_word_t    exp_rdata;
    logic                        exp_invalid;
    logic                        chk_rdata;  // Low when the old value is unknown
  } row_t;

  localparam csr_types_pkg::priv_level_t PRIV_M = csr_types_pkg::M_MODE;
  localparam csr_types_pkg::priv_level_t PRIV_U = csr_types_pkg::U_MODE;

  logic                        CLK = 1'b0;
  logic                        nRST;
  csr_types_pkg::csr_req_t     req;
  csr_types_pkg::trap_update_t trap_upd;
  logic [`CSR_CNT_W-1:0]       mtime;
  logic                        inst_ret;
  csr_types_pkg::csr_word_t    rdata;
  logic                        invalid;
  csr_types_pkg::trap_state_t  trap_state;

  row_t rows [0:63];
  int   n_rows;
  int   errors;
  logic table_ready = 1'b0;
  csr_types_pkg::trap_state_t exp_state;  // Trap state after the last row

  csr_file i_csr_file (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .trap_upd   (trap_upd),
    .mtime      (mtime),
    .inst_ret   (inst_ret),
    .rdata      (rdata),
    .invalid    (invalid),
    .trap_state (trap_state)
  );

  bind csr_file csr_file_asserts i_asserts (
    .CLK        (CLK),
    .nRST       (nRST),
    .req        (req),
    .invalid    (invalid),
    .trap_state (trap_state)
  );

  always #5 CLK = ~CLK;  // 10 ns period

  task automatic add_row(input csr_addr_pkg::csr_op_t op, input csr_addr_pkg::csr_addr_t addr,
                         input csr_types_pkg::csr_word_t wdata,
                         input csr_types_pkg::priv_level_t priv,
                         input csr_types_pkg::csr_word_t exp_rdata, input logic exp_invalid);
    row_t r;
    r             = '0;
    r.req.valid   = 1'b1;
    r.req.op      = op;
    r.req.addr    = addr;
    r.req.wdata   = wdata;
    r.req.priv    = priv;
    r.exp_rdata   = exp_rdata;
    r.exp_invalid = exp_invalid;
    r.chk_rdata   = 1'b1;
    rows[n_rows]  = r;
    n_rows++;
  endtask

  // Plain M-mode read that must not fault
  task automatic read_row(input csr_addr_pkg::csr_addr_t addr,
                          input csr_types_pkg::csr_word_t exp_rdata);
    add_row(csr_addr_pkg::NONE, addr, '0, PRIV_M, exp_rdata, 1'b0);
  endtask

  task automatic build_table();
    csr_types_pkg::csr_word_t w0, w1, w2, w3, w4, w5;
    csr_types_pkg::csr_word_t scratch;
    csr_types_pkg::csr_word_t c_lo, c_hi, i_lo;
    logic [`CSR_CNT_W-1:0]    cyc;
    logic [`CSR_CNT_W-1:0]    mt;
    w0 = $urandom;
    w1 = $urandom;
    w2 = $urandom;
    w3 = $urandom;
    w4 = $urandom;
    w5 = $urandom;

    // Reset values and info registers
    read_row(csr_addr_pkg::MSTATUS_ADDR, `CSR_MSTATUS_RST);
    read_row(csr_addr_pkg::MCOUNTEREN_ADDR, 32'hffff_ffff);
    read_row(csr_addr_pkg::MHARTID_ADDR, `CSR_HARTID);
    read_row(csr_addr_pkg::MISA_ADDR, `CSR_MISA_VAL);
    read_row(csr_addr_pkg::MVENDORID_ADDR, `CSR_MVENDORID);
    read_row(csr_addr_pkg::MARCHID_ADDR, `CSR_MARCHID);
    read_row(csr_addr_pkg::MIMPID_ADDR, `CSR_MIMPID);
    read_row(csr_addr_pkg::MSTATUSH_ADDR, '0);
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MHARTID_ADDR, w0, PRIV_U, `CSR_HARTID, 1'b0);
    rows[n_rows-1].req.valid = 1'b0;  // No strobe, no fault

    // mscratch returns the old value on every op
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MSCRATCH_ADDR, w0, PRIV_M, '0, 1'b0);
    scratch = w0;
    add_row(csr_addr_pkg::SET, csr_addr_pkg::MSCRATCH_ADDR, w1, PRIV_M, scratch, 1'b0);
    scratch = scratch | w1;
    add_row(csr_addr_pkg::CLEAR, csr_addr_pkg::MSCRATCH_ADDR, w2, PRIV_M, scratch, 1'b0);
    scratch = scratch & ~w2;
    read_row(csr_addr_pkg::MSCRATCH_ADDR, scratch);

    // mpp = S plus mie, mpie and tw; mpp comes back as U
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MSTATUS_ADDR, 32'h0020_0888, PRIV_M,
            `CSR_MSTATUS_RST, 1'b0);
    read_row(csr_addr_pkg::MSTATUS_ADDR, 32'h0020_0088);
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MTVEC_ADDR, 32'h8000_0103, PRIV_M, '0, 1'b0);
    read_row(csr_addr_pkg::MTVEC_ADDR, 32'h8000_0100);  // Mode 3 becomes direct
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MIE_ADDR, 32'hffff_ffff, PRIV_M, '0, 1'b0);
    read_row(csr_addr_pkg::MIE_ADDR, 32'h0000_0888);

    // Faults
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MSCRATCH_ADDR, w3, PRIV_U, scratch, 1'b1);
    read_row(csr_addr_pkg::MSCRATCH_ADDR, scratch);
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MHARTID_ADDR, w3, PRIV_M, `CSR_HARTID, 1'b1);
    add_row(csr_addr_pkg::SET, csr_addr_pkg::csr_addr_t'(12'h7c0), w3, PRIV_M, '0, 1'b1);

    // Counters frozen by cy and ir inhibit
    c_hi = $urandom;
    c_lo = $urandom;
    i_lo = $urandom;
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MCOUNTINHIBIT_ADDR, 32'h5, PRIV_M, '0, 1'b0);
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MCYCLEH_ADDR, c_hi, PRIV_M, '0, 1'b0);
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MCYCLE_ADDR, c_lo, PRIV_M, '0, 1'b0);
    rows[n_rows-1].chk_rdata = 1'b0;  // Cycles since reset
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MINSTRET_ADDR, i_lo, PRIV_M, '0, 1'b0);
    rows[n_rows-1].chk_rdata = 1'b0;
    read_row(csr_addr_pkg::MCYCLE_ADDR, c_lo);
    read_row(csr_addr_pkg::MCYCLEH_ADDR, c_hi);
    read_row(csr_addr_pkg::MINSTRET_ADDR, i_lo);

    // Release cycle inhibit; it still holds at this row's edge
    add_row(csr_addr_pkg::CLEAR, csr_addr_pkg::MCOUNTINHIBIT_ADDR, 32'h1, PRIV_M,
            32'h5, 1'b0);
    cyc = {c_hi, c_lo};
    read_row(csr_addr_pkg::MCYCLE_ADDR, cyc[31:0]);
    cyc = cyc + 64'd1;
    read_row(csr_addr_pkg::MCYCLE_ADDR, cyc[31:0]);
    read_row(csr_addr_pkg::MINSTRET_ADDR, i_lo);

    // time views follow the mtime input of the same row
    mt = {$urandom, $urandom};
    add_row(csr_addr_pkg::NONE, csr_addr_pkg::TIME_ADDR, '0, PRIV_M, mt[31:0], 1'b0);
    rows[n_rows-1].mtime = mt;
    mt = {$urandom, $urandom};
    add_row(csr_addr_pkg::NONE, csr_addr_pkg::TIMEH_ADDR, '0, PRIV_U, mt[63:32], 1'b0);
    rows[n_rows-1].mtime = mt;

    // User cycle view closed by mcounteren
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MCOUNTEREN_ADDR, '0, PRIV_M,
            32'hffff_ffff, 1'b0);
    add_row(csr_addr_pkg::NONE, csr_addr_pkg::CYCLE_ADDR, '0, PRIV_U, '0, 1'b1);

    // Injected mepc beats the CSR write
    add_row(csr_addr_pkg::WRITE, csr_addr_pkg::MEPC_ADDR, w4, PRIV_M, '0, 1'b0);
    rows[n_rows-1].upd.inject_mepc = 1'b1;
    rows[n_rows-1].upd.mepc        = w5;
    read_row(csr_addr_pkg::MEPC_ADDR, w5);

    // Legalized writes and the injected mepc, mip and mcause untouched
    exp_state         = '0;
    exp_state.mstatus = 32'h0020_0088;
    exp_state.mtvec   = 32'h8000_0100;
    exp_state.mie     = 32'h0000_0888;
    exp_state.mepc    = w5;
  endtask

  task automatic apply_row(input row_t r);
    req      = r.req;
    trap_upd = r.upd;
    mtime    = r.mtime;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  initial begin
    errors   = 0;
    n_rows   = 0;
    nRST     = 1'b0;
    req      = '0;
    trap_upd = '0;
    mtime    = '0;
    inst_ret = 1'b0;
    void'($urandom(32'hd85593f3));
    build_table();
    table_ready = 1'b1;

    repeat (5) @(posedge CLK);
    #1;
    nRST     = 1'b1;
    inst_ret = 1'b1;  // Retire every cycle

    for (int i = 0; i < n_rows; i++) begin
      @(posedge CLK);
      #1;
      apply_row(rows[i]);
      #5;  // Combinational outputs settled
      if (rows[i].chk_rdata) begin
        check_value($sformatf("rdata row %0d", i), rdata, rows[i].exp_rdata);
      end
      check_value($sformatf("invalid row %0d", i), {31'b0, invalid},
                  {31'b0, rows[i].exp_invalid});
    end

    @(posedge CLK);
    #1;
    req      = '0;
    trap_upd = '0;
    check_value("trap_state.mstatus", trap_state.mstatus, exp_state.mstatus);
    check_value("trap_state.mtvec", trap_state.mtvec, exp_state.mtvec);
    check_value("trap_state.mie", trap_state.mie, exp_state.mie);
    check_value("trap_state.mip", trap_state.mip, exp_state.mip);
    check_value("trap_state.mepc", trap_state.mepc, exp_state.mepc);
    check_value("trap_state.mcause", trap_state.mcause, exp_state.mcause);
    errors += i_csr_file.i_asserts.fail_count;
    $display("%0d errors in %0d rows", errors, n_rows);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    #(n_rows * 10 + 200);
    $display("Timeout: the stimulus table did not complete in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

/* build.f */
+incdir+source
source/csr_addr_pkg.sv
source/csr_types_pkg.sv
source/csr_access_check.sv
source/machine_trap_csrs.sv
source/perf_counters.sv
source/csr_read_mux.sv
source/csr_file.sv
sim/csr_file_asserts.sv
sim/csr_file_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' build.f) source/csr_cfg.svh

obj_dir/Vcsr_file_tb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module csr_file_tb -o Vcsr_file_tb

run: obj_dir/Vcsr_file_tb
	./obj_dir/Vcsr_file_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
